// File: r5_pkg.sv
`default_nettype none

package r5_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN = 32;  // RV32 only

  typedef logic [XLEN-1:0] xlen_t;  // Data word
  typedef logic [5-1:0]    gpr_adr_t;  // Register number

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    OP_IMM  = 7'b0010011,
    OP      = 7'b0110011,
    AUIPC   = 7'b0010111,
    LUI     = 7'b0110111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    ILLEGAL = 7'b0000000  // Anything not supported
  } opc_t;

  // ALU operations
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } alu_op_t;

endpackage: r5_pkg

`default_nettype wire

// File: r5_gpr.sv
`default_nettype none

module r5_gpr (
  input  logic             clk,
  input  logic             rst,
  // Read ports
  input  r5_pkg::gpr_adr_t rs1,
  input  r5_pkg::gpr_adr_t rs2,
  output r5_pkg::xlen_t    rd1,
  output r5_pkg::xlen_t    rd2,
  // Write port
  input  logic             wen,
  input  r5_pkg::gpr_adr_t adr,
  input  r5_pkg::xlen_t    dat
);

  // Register array, x0 never written
  r5_pkg::xlen_t gpr [0:31];

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (wen && (adr != '0)) begin
      gpr[adr] <= dat;
    end
  end

  // Combinational reads
  always_comb begin
    rd1 = (rs1 == '0) ? '0 : gpr[rs1];  // x0 reads zero
    rd2 = (rs2 == '0) ? '0 : gpr[rs2];
  end

endmodule: r5_gpr

`default_nettype wire

// File: r5_decode.sv
`default_nettype none

module r5_decode (
  input  logic              clk,
  input  logic              rst,
  // Instruction source handshake
  input  logic              req,
  output logic              ack,
  input  r5_pkg::xlen_t     instr,
  input  r5_pkg::xlen_t     pc,
  // Decode record
  output logic              dec_vld,
  output r5_pkg::opc_t      dec_opc,
  output r5_pkg::alu_op_t   dec_alu_op,
  output r5_pkg::gpr_adr_t  dec_rs1,
  output r5_pkg::gpr_adr_t  dec_rs2,
  output r5_pkg::gpr_adr_t  dec_rd,
  output logic              dec_wen,
  output r5_pkg::xlen_t     dec_imm,
  output r5_pkg::xlen_t     dec_pc,
  output logic              dec_use_imm
);

  typedef enum logic {IDLE, ACKED} state_t;

  state_t          state;
  logic            capture;
  r5_pkg::opc_t    opc;
  r5_pkg::alu_op_t alu_op;
  r5_pkg::xlen_t   imm;
  logic            f7b5;   // funct7 bit 5 selects SUB and SRA
  logic [2:0]      funct3;

  //////////////////////////////////////////////////////////////////////
  // Four-phase acceptance
  //////////////////////////////////////////////////////////////////////

  assign capture = (state == IDLE) && req;
  assign ack     = (state == ACKED);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state   <= IDLE;
      dec_vld <= 1'b0;
    end else begin
      dec_vld <= capture;  // One cycle pulse
      case (state)
        IDLE:    if (req)  state <= ACKED;
        ACKED:   if (!req) state <= IDLE;  // Wait for req release
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Field decode
  //////////////////////////////////////////////////////////////////////

  assign funct3 = instr[14:12];
  assign f7b5   = instr[30];

  always_comb begin
    case (instr[6:0])
      r5_pkg::LOAD, r5_pkg::STORE, r5_pkg::OP_IMM, r5_pkg::OP,
      r5_pkg::AUIPC, r5_pkg::LUI, r5_pkg::JAL, r5_pkg::JALR:
        opc = r5_pkg::opc_t'(instr[6:0]);
      default: opc = r5_pkg::ILLEGAL;
    endcase
    // Immediate by format
    case (opc)
      r5_pkg::LOAD, r5_pkg::OP_IMM, r5_pkg::JALR:
        imm = {{20{instr[31]}}, instr[31:20]};                              // I
      r5_pkg::STORE: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};   // S
      r5_pkg::LUI, r5_pkg::AUIPC: imm = {instr[31:12], 12'h000};          // U
      r5_pkg::JAL: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;
    endcase
    // ALU operation from funct3, funct7 only for OP and immediate shifts
    case (funct3)
      3'b000:  alu_op = (opc == r5_pkg::OP && f7b5) ? r5_pkg::SUB : r5_pkg::ADD;
      3'b001:  alu_op = r5_pkg::SLL;
      3'b010:  alu_op = r5_pkg::SLT;
      3'b011:  alu_op = r5_pkg::SLTU;
      3'b100:  alu_op = r5_pkg::XOR;
      3'b101:  alu_op = f7b5 ? r5_pkg::SRA : r5_pkg::SRL;
      3'b110:  alu_op = r5_pkg::OR;
      default: alu_op = r5_pkg::AND;
    endcase
  end

  // Decode record held from capture
  always_ff @(posedge clk) begin
    if (capture) begin
      dec_opc     <= opc;
      dec_alu_op  <= alu_op;
      dec_rs1     <= instr[19:15];
      dec_rs2     <= instr[24:20];
      dec_rd      <= instr[11:7];
      dec_imm     <= imm;
      dec_pc      <= pc;
      dec_use_imm <= opc inside {r5_pkg::OP_IMM, r5_pkg::LOAD, r5_pkg::STORE,
                                 r5_pkg::JALR, r5_pkg::AUIPC};
      dec_wen     <= (instr[11:7] != '0) &&
                     (opc inside {r5_pkg::OP, r5_pkg::OP_IMM, r5_pkg::LUI, r5_pkg::AUIPC,
                                  r5_pkg::JAL, r5_pkg::JALR, r5_pkg::LOAD});
    end
  end

endmodule: r5_decode

`default_nettype wire

// File: r5_execute.sv
`default_nettype none

module r5_execute (
  // Decode fields
  input  r5_pkg::opc_t    dec_opc,
  input  r5_pkg::alu_op_t dec_alu_op,
  input  logic            dec_use_imm,
  input  r5_pkg::xlen_t   dec_imm,
  input  r5_pkg::xlen_t   dec_pc,
  // Register operands
  input  r5_pkg::xlen_t   rs1_dat,
  input  r5_pkg::xlen_t   rs2_dat,
  // Results
  output r5_pkg::xlen_t   alu_res,
  output r5_pkg::xlen_t   pc_inc
);

  r5_pkg::xlen_t   opa;
  r5_pkg::xlen_t   opb;
  r5_pkg::alu_op_t op;
  logic [4:0]      shamt;

  //////////////////////////////////////////////////////////////////////
  // Operand selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    opa = (dec_opc == r5_pkg::AUIPC) ? dec_pc : rs1_dat;  // PC relative
    opb = dec_use_imm ? dec_imm : rs2_dat;
    // Address and link target computations always add
    case (dec_opc)
      r5_pkg::LOAD, r5_pkg::STORE, r5_pkg::JALR, r5_pkg::AUIPC: op = r5_pkg::ADD;
      default: op = dec_alu_op;
    endcase
  end

  assign shamt = opb[4:0];  // RV32 shift amount

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op)
      r5_pkg::ADD:  alu_res = opa + opb;
      r5_pkg::SUB:  alu_res = opa - opb;
      r5_pkg::SLL:  alu_res = opa << shamt;
      r5_pkg::SLT:  alu_res = r5_pkg::xlen_t'($signed(opa) < $signed(opb));
      r5_pkg::SLTU: alu_res = r5_pkg::xlen_t'(opa < opb);
      r5_pkg::XOR:  alu_res = opa ^ opb;
      r5_pkg::SRL:  alu_res = opa >> shamt;
      r5_pkg::SRA:  alu_res = r5_pkg::xlen_t'($signed(opa) >>> shamt);  // Keeps sign
      r5_pkg::OR:   alu_res = opa | opb;
      r5_pkg::AND:  alu_res = opa & opb;
      default:      alu_res = '0;
    endcase
  end

  // Link value for JAL and JALR
  assign pc_inc = dec_pc + r5_pkg::xlen_t'(4);

endmodule: r5_execute

`default_nettype wire

// File: r5_lsu.sv
`default_nettype none

module r5_lsu #(
  parameter int unsigned DMEM_AW = 8  // Word address width
)(
  input  logic          clk,
  input  logic          rst,
  // Decode fields
  input  logic          dec_vld,
  input  r5_pkg::opc_t  dec_opc,
  // Access
  input  r5_pkg::xlen_t adr,   // Byte address
  input  r5_pkg::xlen_t wdat,  // Store data
  output r5_pkg::xlen_t rdat   // Load data, one cycle late
);

  r5_pkg::xlen_t      mem [0:2**DMEM_AW-1];
  logic [DMEM_AW-1:0] widx;  // Word index, upper bits dropped

  assign widx = adr[DMEM_AW+1:2];

  // SW only on a valid store
  always_ff @(posedge clk) begin
    if (dec_vld && (dec_opc == r5_pkg::STORE)) begin
      mem[widx] <= wdat;
    end
  end

  // Read data registered every cycle
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      rdat <= '0;
    end else begin
      rdat <= mem[widx];
    end
  end

endmodule: r5_lsu

`default_nettype wire

// File: r5_wbu.sv
`default_nettype none

module r5_wbu (
  input  logic             clk,
  input  logic             rst,
  // Decode fields
  input  logic             dec_vld,
  input  logic             dec_wen,
  input  r5_pkg::gpr_adr_t dec_rd,
  input  r5_pkg::opc_t     dec_opc,
  // Result sources
  input  r5_pkg::xlen_t    alu,  // ALU result
  input  r5_pkg::xlen_t    pcs,  // PC plus 4
  input  r5_pkg::xlen_t    lui,  // Upper immediate
  input  r5_pkg::xlen_t    lsu,  // RAM read data
  // Register file write port
  output logic             wen,
  output r5_pkg::gpr_adr_t adr,
  output r5_pkg::xlen_t    dat
);

  r5_pkg::opc_t  sel;  // Opcode of the result in flight
  r5_pkg::xlen_t tmp;  // Pre-selected value

  // Destination and select
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wen <= 1'b0;
      adr <= '0;
      sel <= r5_pkg::ILLEGAL;
    end else begin
      wen <= dec_vld && dec_wen;
      adr <= dec_rd;
      sel <= dec_opc;
    end
  end

  // Pre-multiplexer, loads are resolved after the RAM
  always_ff @(posedge clk) begin
    case (dec_opc)
      r5_pkg::OP, r5_pkg::OP_IMM, r5_pkg::AUIPC: tmp <= alu;
      r5_pkg::JAL, r5_pkg::JALR:                  tmp <= pcs;  // Link
      r5_pkg::LUI:                                tmp <= lui;
      default:                                    tmp <= '0;
    endcase
  end

  // Load multiplexer
  assign dat = (sel == r5_pkg::LOAD) ? lsu : tmp;

endmodule: r5_wbu

`default_nettype wire

// File: r5_core.sv
`default_nettype none

module r5_core #(
  parameter int unsigned DMEM_AW = 8  // Data RAM word address width
)(
  input  logic             clk,
  input  logic             rst,
  // Instruction source
  input  logic             req,
  output logic             ack,
  input  r5_pkg::xlen_t    instr,
  input  r5_pkg::xlen_t    pc,
  // Write-back port
  output logic             wen,
  output r5_pkg::gpr_adr_t adr,
  output r5_pkg::xlen_t    dat
);

  //////////////////////////////////////////////////////////////////////
  // Decode record and datapath wires
  //////////////////////////////////////////////////////////////////////

  logic             dec_vld;
  r5_pkg::opc_t     dec_opc;
  r5_pkg::alu_op_t  dec_alu_op;
  r5_pkg::gpr_adr_t dec_rs1;
  r5_pkg::gpr_adr_t dec_rs2;
  r5_pkg::gpr_adr_t dec_rd;
  logic             dec_wen;
  r5_pkg::xlen_t    dec_imm;
  r5_pkg::xlen_t    dec_pc;
  logic             dec_use_imm;
  r5_pkg::xlen_t    rs1_dat;
  r5_pkg::xlen_t    rs2_dat;
  r5_pkg::xlen_t    alu_res;
  r5_pkg::xlen_t    pc_inc;
  r5_pkg::xlen_t    ld_dat;

  r5_decode u_decode (
    .clk, .rst, .req, .ack, .instr, .pc,
    .dec_vld, .dec_opc, .dec_alu_op, .dec_rs1, .dec_rs2, .dec_rd,
    .dec_wen, .dec_imm, .dec_pc, .dec_use_imm
  );

  // Written back from the WBU outputs
  r5_gpr u_gpr (
    .clk, .rst,
    .rs1 (dec_rs1), .rs2 (dec_rs2), .rd1 (rs1_dat), .rd2 (rs2_dat),
    .wen, .adr, .dat
  );

  r5_execute u_execute (
    .dec_opc, .dec_alu_op, .dec_use_imm, .dec_imm, .dec_pc,
    .rs1_dat, .rs2_dat, .alu_res, .pc_inc
  );

  r5_lsu #(.DMEM_AW (DMEM_AW)) u_lsu (
    .clk, .rst, .dec_vld, .dec_opc,
    .adr (alu_res), .wdat (rs2_dat), .rdat (ld_dat)
  );

  r5_wbu u_wbu (
    .clk, .rst, .dec_vld, .dec_wen, .dec_rd, .dec_opc,
    .alu (alu_res), .pcs (pc_inc), .lui (dec_imm), .lsu (ld_dat),
    .wen, .adr, .dat
  );

endmodule: r5_core

`default_nettype wire

// File: r5_core_tb.sv
`default_nettype none

module r5_core_tb;

  localparam int DMEM_AW = 8;
  // RV32I major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;

  logic        clk;
  logic        rst;
  logic        req;
  logic        ack;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        wen;
  logic [4:0]  adr;
  logic [31:0] dat;
  logic [31:0] ref_gpr [0:31];            // Reference registers
  logic [31:0] ref_mem [0:2**DMEM_AW-1];  // Reference data RAM
  logic [31:0] lfsr = 32'hd98b76ee;
  int          errors = 0;
  int          n_tests = 0;

  r5_core #(.DMEM_AW (DMEM_AW)) UUT (
    .clk, .rst, .req, .ack, .instr, .pc, .wen, .adr, .dat
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Six tests of up to 2000 cycles each
  initial begin
    #(6 * 2000 * 10);
    $display("Watchdog expired, the run did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Encoders, random source, reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // SW
  endfunction

  function automatic logic [31:0] jtype_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return 32'($signed(a) < $signed(b));
      3'd3:    return 32'(a < b);
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Expected write-back of one instruction and reference update
  task automatic predict(input logic [31:0] ins, input logic [31:0] ipc, output logic w,
                         output logic [4:0] rd, output logic [31:0] val);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] ea;
    logic [2:0]  f3;
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = ref_gpr[ins[19:15]];
    b     = ref_gpr[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    w     = 1'b1;
    val   = '0;
    case (ins[6:0])
      OPC_OP:  val = alu_ref(f3, ins[30] && (f3 == 3'd0 || f3 == 3'd5), a, b);
      OPC_IMM: val = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);  // No SUBI
      OPC_LUI:   val = {ins[31:12], 12'h000};
      OPC_AUIPC: val = ipc + {ins[31:12], 12'h000};
      OPC_JAL, OPC_JALR: val = ipc + 32'd4;  // Link
      OPC_LOAD: begin
        ea  = a + imm_i;
        val = ref_mem[ea[DMEM_AW+1:2]];  // Word index wraps
      end
      OPC_STORE: begin
        ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        ref_mem[ea[DMEM_AW+1:2]] = b;
        w = 1'b0;
      end
      default: w = 1'b0;
    endcase
    if (rd == 5'd0) w = 1'b0;  // x0 never written
    if (w) ref_gpr[rd] = val;
  endtask

  task automatic mismatch(input string what, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic protocol_fail(input string msg);
    errors++;
    $display("At time %0t the DUT failed: %s", $time, msg);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Four-phase issue with write-back check
  //////////////////////////////////////////////////////////////////////

  task automatic issue(input logic [31:0] ins, input logic [31:0] ipc, input int gap);
    logic        exp_wen;
    logic [4:0]  exp_rd;
    logic [31:0] exp_val;
    int          n;
    predict(ins, ipc, exp_wen, exp_rd, exp_val);
    repeat (gap) @(posedge clk);  // Source idle time
    @(negedge clk);
    if (ack !== 1'b0) protocol_fail("ack still high before req was raised");
    @(posedge clk);
    req   <= 1'b1;
    instr <= ins;
    pc    <= ipc;
    n = 0;
    while (ack !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (ack !== 1'b1) protocol_fail("ack never rose after req");
    if (wen !== 1'b0) protocol_fail("wen rose before the result was due");
    @(posedge clk);
    req <= 1'b0;  // Release once ack seen
    @(negedge clk);  // One cycle after capture
    if (ack !== 1'b1) protocol_fail("ack dropped while req was still high");
    if (wen !== exp_wen) mismatch("wen", 32'(wen), 32'(exp_wen));
    if (exp_wen && adr !== exp_rd) mismatch("adr", 32'(adr), 32'(exp_rd));
    if (exp_wen && dat !== exp_val) mismatch("dat", dat, exp_val);
    @(negedge clk);
    if (wen !== 1'b0) protocol_fail("wen stayed high for more than one cycle");
    n = 0;
    while (ack !== 1'b0 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (ack !== 1'b0) protocol_fail("ack never fell after req was dropped");
  endtask

  task automatic end_test(input string name, input int err0);
    n_tests++;
    if (errors == err0) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: %0d errors", n_tests, name, errors - err0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_and_x0();
    int err0;
    err0 = errors;
    @(negedge clk);
    if (ack !== 1'b0) protocol_fail("ack high after reset");
    if (wen !== 1'b0) protocol_fail("wen high after reset");
    issue(itype_word(12'd5, 5'd0, 3'd0, 5'd0, OPC_IMM), 32'h0, 0);  // ADDI x0
    end_test("reset and x0", err0);
  endtask

  task automatic alu_ops();
    int  err0;
    logic sh;
    err0 = errors;
    issue(itype_word(12'hFF9, 5'd0, 3'd0, 5'd1, OPC_IMM), 32'h0, 0);  // x1 = -7
    issue(itype_word(12'd13, 5'd0, 3'd0, 5'd2, OPC_IMM), 32'h0, 0);
    issue(itype_word(12'h7FF, 5'd0, 3'd0, 5'd3, OPC_IMM), 32'h0, 0);
    issue(itype_word(12'h800, 5'd0, 3'd0, 5'd4, OPC_IMM), 32'h0, 0);  // Most negative
    for (int f = 0; f < 8; f++) begin
      sh = (f == 1 || f == 5);
      issue(rtype_word(7'h00, 5'd2, 5'd1, f[2:0], 5'(10 + f)), 32'h0, 0);
      if (f == 0 || f == 5) issue(rtype_word(7'h20, 5'd2, 5'd1, f[2:0], 5'(18 + f)), 32'h0, 0);
      issue(itype_word(sh ? 12'd3 : 12'h9C5, 5'd1, f[2:0], 5'(24 + f), OPC_IMM), 32'h0, 0);
      if (f == 5) issue(itype_word(12'h403, 5'd1, 3'd5, 5'd31, OPC_IMM), 32'h0, 0);  // SRAI
    end
    end_test("alu", err0);
  endtask

  task automatic upper_imm();
    int err0;
    err0 = errors;
    issue({20'hABCDE, 5'd6, OPC_LUI}, 32'h0, 0);
    issue({20'h80001, 5'd7, OPC_AUIPC}, 32'h0000_0000, 0);
    issue({20'h80001, 5'd7, OPC_AUIPC}, 32'h0000_1000, 0);
    issue({20'h00FFF, 5'd8, OPC_AUIPC}, 32'hFFFF_F000, 0);  // Carry out dropped
    issue({20'h12345, 5'd9, OPC_AUIPC}, 32'h8000_0004, 0);
    end_test("lui and auipc", err0);
  endtask

  task automatic jump_link();
    int err0;
    err0 = errors;
    issue(jtype_word(21'h100, 5'd8), 32'h0000_0200, 0);
    issue(itype_word(12'd4, 5'd1, 3'd0, 5'd9, OPC_JALR), 32'hFFFF_FFFC, 0);  // Link wraps
    issue(jtype_word(21'h1FFFF0, 5'd0), 32'h0000_0040, 0);  // No write to x0
    end_test("jal and jalr", err0);
  endtask

  task automatic store_load();
    int err0;
    err0 = errors;
    issue(itype_word(12'h400, 5'd0, 3'd0, 5'd10, OPC_IMM), 32'h0, 0);  // One RAM size
    issue(stype_word(12'h008, 5'd1, 5'd0), 32'h0, 0);
    issue(stype_word(12'h3FC, 5'd2, 5'd0), 32'h0, 0);   // Last word
    issue(stype_word(12'h000, 5'd3, 5'd10), 32'h0, 0);  // Wraps to word 0
    issue(stype_word(12'h7F0, 5'd4, 5'd0), 32'h0, 0);   // Wraps to word 252
    issue(itype_word(12'h008, 5'd0, 3'd2, 5'd12, OPC_LOAD), 32'h0, 0);
    issue(itype_word(12'h3FC, 5'd0, 3'd2, 5'd13, OPC_LOAD), 32'h0, 0);
    issue(itype_word(12'h000, 5'd0, 3'd2, 5'd14, OPC_LOAD), 32'h0, 0);
    issue(itype_word(12'hFF0, 5'd10, 3'd2, 5'd15, OPC_LOAD), 32'h0, 0);
    end_test("sw and lw", err0);
  endtask

  task automatic random_alu();
    int          err0;
    int          gap;
    logic [31:0] ins;
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    err0 = errors;
    for (int k = 0; k < 50; k++) begin
      gap = rnd(2);
      f3  = 3'(rnd(3));
      alt = 1'(rnd(1));
      rd  = 5'(rnd(5));
      rs1 = 5'(rnd(5));
      rs2 = 5'(rnd(5));
      if (rnd(1)) begin
        ins = rtype_word({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0}, rs2, rs1, f3, rd);
      end else if (f3 == 3'd1 || f3 == 3'd5) begin
        ins = itype_word({1'b0, alt && f3 == 3'd5, 5'b0, rs2}, rs1, f3, rd, OPC_IMM);  // Shifts
      end else begin
        ins = itype_word(12'(rnd(12)), rs1, f3, rd, OPC_IMM);
      end
      issue(ins, 32'h0, gap);
    end
    end_test("random alu", err0);
  endtask

  initial begin
    rst   = 1'b1;
    req   = 1'b0;
    instr = '0;
    pc    = '0;
    for (int i = 0; i < 32; i++) begin
      ref_gpr[i] = '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    reset_and_x0();
    alu_ops();
    upper_imm();
    jump_link();
    store_load();
    random_alu();
    $display("%0d tests run, %0d errors", n_tests, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule: r5_core_tb

`default_nettype wire

// File: list.f
r5_pkg.sv
r5_gpr.sv
r5_decode.sv
r5_execute.sv
r5_lsu.sv
r5_wbu.sv
r5_core.sv
r5_core_tb.sv
